//--- Bender.yml
package:
  name: zx_tape

sources:
  - hdl/zx_bus_pkg.sv
  - hdl/tape_pkg.sv
  - hdl/tape_wr_if.sv
  - hdl/tape_rd_if.sv
  - hdl/tape_upload.sv
  - hdl/tape_store.sv
  - hdl/tape_loader.sv
  - hdl/zx_tape_top.sv
  - target: test
    files:
      - tb/tb_tape_model.sv
      - tb/tb_zx_tape_top.sv

//--- files.f
hdl/zx_bus_pkg.sv
hdl/tape_pkg.sv
hdl/tape_wr_if.sv
hdl/tape_rd_if.sv
hdl/tape_upload.sv
hdl/tape_store.sv
hdl/tape_loader.sv
hdl/zx_tape_top.sv
tb/tb_tape_model.sv
tb/tb_zx_tape_top.sv

//--- hdl/tape_loader.sv
// Traps the ROM LOAD entry, overlays the wait loop and streams the image to RAM
// Needs cpu_ce pulses at least two clocks apart so the read data keeps up
`timescale 1ns/1ns
`default_nettype none

module tape_loader
	import zx_bus_pkg::*, tape_pkg::*;
#(
	parameter int TAPE_AW = $bits(tape_addr_t)
) (
	input wire            clk_sys,
	input wire            reset,
	tape_rd_if.loader     rd_bus,
	input wire cpu_addr_t cpu_addr,
	input wire            cpu_m1,
	input wire            cpu_ce,
	input wire            model_zx81,
	output logic          patch_valid,
	output byte_t         patch_data,
	output logic          ram_we,
	output cpu_addr_t     ram_addr,
	output byte_t         ram_data
);

	typedef enum logic [1:0] {
		IDLE,
		STREAM,  // Loop byte is NOP
		DRAINED  // Loop byte is SCF
	} load_state_t;

	load_state_t      state;
	logic [TAPE_AW:0] offset; // Next image byte to write
	logic             m1_q;
	logic             m1_rise;
	logic             at_trap;
	logic             outside;
	logic             take;
	cpu_addr_t        trap_addr;
	cpu_addr_t        load_end;
	cpu_addr_t        wr_base;
	logic [2:0]       patch_idx;

	// ==============================
	// Model and fetch decode
	// ==============================

	assign trap_addr = model_zx81 ? ZX81_TRAP_ADDR : ZX80_TRAP_ADDR;
	assign load_end  = model_zx81 ? ZX81_LOAD_END : ZX80_LOAD_END;

	assign m1_rise = cpu_m1 && !m1_q;
	assign at_trap = (cpu_addr == trap_addr);
	assign outside = (cpu_addr < trap_addr) || (cpu_addr >= load_end); // Left the ROM routine

	// .p images start past the system variables
	assign wr_base = (rd_bus.ftype == TAPE_TYPE_P) ? RAM_BASE + cpu_addr_t'(P_FILE_SKIP)
		: RAM_BASE;

	assign take = (state == STREAM) && cpu_ce && (offset < rd_bus.len);

	assign rd_bus.raddr = offset[TAPE_AW-1:0];

	// ==============================
	// Load sequencing
	// ==============================

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			state  <= IDLE;
			offset <= '0;
			m1_q   <= 1'b0;
			ram_we <= 1'b0;
		end else begin
			m1_q   <= cpu_m1;
			ram_we <= 1'b0;
			if (m1_rise && at_trap && rd_bus.ready) begin
				state  <= STREAM; // Restart from the first byte
				offset <= '0;
			end else if (m1_rise && outside) begin
				state <= IDLE;
			end else if (take) begin
				ram_we <= 1'b1;
				offset <= offset + 1'b1;
				if (offset + 1'b1 == rd_bus.len) begin
					state <= DRAINED;
				end
			end else if (state == IDLE) begin
				offset <= '0; // Primes the read of byte 0
			end
		end
	end

	// Write payload
	always_ff @(posedge clk_sys) begin
		if (take) begin
			ram_addr <= wr_base + cpu_addr_t'(offset);
			ram_data <= rd_bus.rdata;
		end
	end

	// ==============================
	// Patch overlay
	// ==============================

	assign patch_idx   = 3'(cpu_addr - trap_addr);
	assign patch_valid = (state != IDLE)
		&& (cpu_addr >= trap_addr)
		&& (cpu_addr < trap_addr + cpu_addr_t'(PATCH_LEN));

	always_comb begin
		case (patch_idx)
			3'd0: patch_data = PATCH_XOR_A;
			3'd1: patch_data = (state == DRAINED) ? OP_SCF : OP_NOP; // Releases the loop
			3'd2: patch_data = PATCH_JR_NC;
			3'd3: patch_data = PATCH_JR_OFF;
			3'd4: patch_data = PATCH_JP;
			3'd5: patch_data = model_zx81 ? ZX81_JUMP_LO : ZX80_JUMP_LO;
			3'd6: patch_data = PATCH_JUMP_HI;
			default: patch_data = 8'hFF; // Outside the routine
		endcase
	end

	// RAM writes only come out of an active load
	ram_we_while_loading: assert property (
		@(posedge clk_sys) disable iff (reset)
		ram_we |-> (state != IDLE)
	) else $error("RAM write outside a tape load");

	// Never clobber ROM space
	ram_we_above_base: assert property (
		@(posedge clk_sys) disable iff (reset)
		ram_we |-> (ram_addr >= RAM_BASE)
	) else $error("tape write below main RAM");

endmodule : tape_loader

`default_nettype wire

//--- hdl/tape_pkg.sv
// Tape store types, host download index decode and the loader patch bytes
// The patch is the ZX81/ZX80 wait loop that replaces the ROM LOAD routine
`default_nettype none

package tape_pkg;

	// ==============================
	// Store geometry
	// ==============================

	typedef logic [13:0] tape_addr_t;   // Offset into the tape image
	typedef logic [7:0]  ioctl_index_t; // Host file slot and flags

	localparam int TAPE_DEPTH = 16384;  // Bytes held by the store

	// Download index fields
	localparam int IDX_SLOT_MSB = 4; // Slot number in bits 4..0, zero is the ROM
	localparam int IDX_AUX_BIT  = 5; // Set for CHR and colour uploads
	localparam int IDX_TYPE_BIT = 6; // .p image when set
	localparam int IDX_ROM_BIT  = 7; // Set for non-tape images

	localparam logic TAPE_TYPE_O = 1'b0;
	localparam logic TAPE_TYPE_P = 1'b1;

	// ==============================
	// Patch routine
	// ==============================
	// xor a / loop: nop or scf / jr nc,loop / jp 0x0207 or 0x0203

	localparam int PATCH_LEN = 7;

	localparam logic [7:0] PATCH_XOR_A   = 8'hAF;
	localparam logic [7:0] OP_NOP        = 8'h00; // Keeps the loop spinning
	localparam logic [7:0] OP_SCF        = 8'h37; // Carry set, loop falls through
	localparam logic [7:0] PATCH_JR_NC   = 8'h30;
	localparam logic [7:0] PATCH_JR_OFF  = 8'hFD; // Back to byte 1
	localparam logic [7:0] PATCH_JP      = 8'hC3;
	localparam logic [7:0] ZX81_JUMP_LO  = 8'h07;
	localparam logic [7:0] ZX80_JUMP_LO  = 8'h03;
	localparam logic [7:0] PATCH_JUMP_HI = 8'h02;

endpackage : tape_pkg

`default_nettype wire

//--- hdl/tape_rd_if.sv
// Read port and image description from the tape store to the loader
// rdata follows raddr by one clock
`timescale 1ns/1ns
`default_nettype none

interface tape_rd_if
	import zx_bus_pkg::*;
#(
	parameter int AW = 14
) ();

	logic [AW-1:0] raddr;
	byte_t         rdata;
	logic [AW:0]   len;   // One extra bit so a full store fits
	logic          ftype;
	logic          ready; // Image present

	modport loader (
		output raddr,
		input  rdata,
		input  len,
		input  ftype,
		input  ready
	);

	modport store (
		input  raddr,
		output rdata,
		output len,
		output ftype,
		output ready
	);

endinterface : tape_rd_if

`default_nettype wire

//--- hdl/tape_store.sv
// Tape image memory with registered read and the committed length and type
// An image longer than the store is not supported
`timescale 1ns/1ns
`default_nettype none

module tape_store
	import zx_bus_pkg::*, tape_pkg::*;
#(
	parameter int TAPE_AW = $bits(tape_addr_t)
) (
	input wire       clk_sys,
	input wire       reset,
	tape_wr_if.store wr_bus,
	tape_rd_if.store rd_bus
);

	localparam int DEPTH = 1 << TAPE_AW;

	byte_t mem [0:DEPTH-1];

	// ==============================
	// Byte memory
	// ==============================

	always_ff @(posedge clk_sys) begin
		if (wr_bus.wr) begin
			mem[wr_bus.waddr[TAPE_AW-1:0]] <= wr_bus.wdata;
		end
		rd_bus.rdata <= mem[rd_bus.raddr]; // One clock behind raddr
	end

	// ==============================
	// Image description
	// ==============================

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			rd_bus.len <= '0; // No image after reset
		end else if (wr_bus.commit) begin
			rd_bus.len   <= wr_bus.commit_len[TAPE_AW:0];
			rd_bus.ftype <= wr_bus.commit_type;
		end
	end

	assign rd_bus.ready = |rd_bus.len;

	// Host must never send more than the store can hold
	commit_len_fits: assert property (
		@(posedge clk_sys) disable iff (reset)
		wr_bus.commit |-> (wr_bus.commit_len <= TAPE_DEPTH)
	) else $error("tape image longer than the store");

endmodule : tape_store

`default_nettype wire

//--- hdl/tape_upload.sv
// Picks tape images out of the host download stream
// Assumes ioctl_addr holds the byte count once ioctl_download drops
`timescale 1ns/1ns
`default_nettype none

module tape_upload
	import zx_bus_pkg::*, tape_pkg::*;
(
	input wire               clk_sys,
	input wire               reset,
	input wire               ioctl_download,
	input wire ioctl_index_t ioctl_index,
	input wire               ioctl_wr,
	input wire [24:0]        ioctl_addr,
	input wire byte_t        ioctl_dout,
	tape_wr_if.producer      wr_bus
);

	logic is_tape;
	logic download_q;

	// Tape slots are nonzero with the ROM and aux flags clear
	assign is_tape = (ioctl_index[IDX_SLOT_MSB:0] != '0)
		&& !ioctl_index[IDX_ROM_BIT]
		&& !ioctl_index[IDX_AUX_BIT];

	// ==============================
	// Byte path
	// ==============================

	assign wr_bus.wr    = ioctl_wr && is_tape; // Store writes on the sampling edge
	assign wr_bus.waddr = ioctl_addr;
	assign wr_bus.wdata = ioctl_dout;

	// ==============================
	// End of download
	// ==============================

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			download_q    <= 1'b0;
			wr_bus.commit <= 1'b0;
		end else begin
			download_q    <= ioctl_download;
			wr_bus.commit <= download_q && !ioctl_download && is_tape; // Falling edge
		end
	end

	// Length and type ride along with the commit pulse
	always_ff @(posedge clk_sys) begin
		wr_bus.commit_len  <= ioctl_addr;
		wr_bus.commit_type <= ioctl_index[IDX_TYPE_BIT];
	end

endmodule : tape_upload

`default_nettype wire

//--- hdl/tape_wr_if.sv
// Byte writes and end-of-download commit from the upload decoder to the store
// Addresses and length keep the full host width, the store truncates them
`timescale 1ns/1ns
`default_nettype none

interface tape_wr_if
	import zx_bus_pkg::*;
();

	logic        wr;          // One-cycle byte write
	logic [24:0] waddr;
	byte_t       wdata;

	logic        commit;      // One-cycle pulse at the end of a download
	logic [24:0] commit_len;  // Bytes received
	logic        commit_type; // .o or .p

	modport producer (
		output wr,
		output waddr,
		output wdata,
		output commit,
		output commit_len,
		output commit_type
	);

	modport store (
		input wr,
		input waddr,
		input wdata,
		input commit,
		input commit_len,
		input commit_type
	);

endinterface : tape_wr_if

`default_nettype wire

//--- hdl/zx_bus_pkg.sv
// CPU-side address and data types plus the ROM load routine addresses
// Trap addresses assume the stock ZX81 and ZX80 ROM images
`default_nettype none

package zx_bus_pkg;

	// ==============================
	// Bus types
	// ==============================

	typedef logic [15:0] cpu_addr_t; // Z80 address bus
	typedef logic [7:0]  byte_t;     // Z80 data bus

	// ==============================
	// ROM load routine
	// ==============================

	// ZX81 LOAD entry and the first address past the routine
	localparam cpu_addr_t ZX81_TRAP_ADDR = 16'h0347;
	localparam cpu_addr_t ZX81_LOAD_END  = 16'h03C3;

	// ZX80 equivalents
	localparam cpu_addr_t ZX80_TRAP_ADDR = 16'h0207;
	localparam cpu_addr_t ZX80_LOAD_END  = 16'h024D;

	// ==============================
	// Main RAM layout
	// ==============================

	localparam cpu_addr_t RAM_BASE = 16'h4000; // Start of main RAM

	// .p images omit the system variables below 0x4009
	localparam int P_FILE_SKIP = 9;

endpackage : zx_bus_pkg

`default_nettype wire

//--- hdl/zx_tape_top.sv
// Tape fast-load block for a ZX81/ZX80 core, host download in and RAM writes out
// The CPU side must mux patch_data over ROM reads while patch_valid is high
`timescale 1ns/1ns
`default_nettype none

module zx_tape_top
	import zx_bus_pkg::*, tape_pkg::*;
#(
	parameter int TAPE_AW = 14
) (
	input wire               clk_sys,
	input wire               reset,
	// Host download
	input wire               ioctl_download,
	input wire ioctl_index_t ioctl_index,
	input wire               ioctl_wr,
	input wire [24:0]        ioctl_addr,
	input wire byte_t        ioctl_dout,
	// CPU side
	input wire cpu_addr_t    cpu_addr,
	input wire               cpu_m1,
	input wire               cpu_ce,
	input wire               model_zx81, // Low selects the ZX80 ROM routine
	output logic             tape_ready,
	output logic             patch_valid,
	output byte_t            patch_data,
	output logic             ram_we,
	output cpu_addr_t        ram_addr,
	output byte_t            ram_data
);

	tape_wr_if wr_bus ();
	tape_rd_if #(.AW(TAPE_AW)) rd_bus ();

	tape_upload upload0 (
		.clk_sys        (clk_sys),
		.reset          (reset),
		.ioctl_download (ioctl_download),
		.ioctl_index    (ioctl_index),
		.ioctl_wr       (ioctl_wr),
		.ioctl_addr     (ioctl_addr),
		.ioctl_dout     (ioctl_dout),
		.wr_bus         (wr_bus.producer)
	);

	tape_store #(.TAPE_AW(TAPE_AW)) store0 (
		.clk_sys (clk_sys),
		.reset   (reset),
		.wr_bus  (wr_bus.store),
		.rd_bus  (rd_bus.store)
	);

	tape_loader #(.TAPE_AW(TAPE_AW)) loader0 (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.rd_bus      (rd_bus.loader),
		.cpu_addr    (cpu_addr),
		.cpu_m1      (cpu_m1),
		.cpu_ce      (cpu_ce),
		.model_zx81  (model_zx81),
		.patch_valid (patch_valid),
		.patch_data  (patch_data),
		.ram_we      (ram_we),
		.ram_addr    (ram_addr),
		.ram_data    (ram_data)
	);

	assign tape_ready = rd_bus.ready;

endmodule : zx_tape_top

`default_nettype wire

//--- tb/tb_tape_model.sv
// Reference model for the tape fast-load block, built from the load rules
// Holds one image at a time, the last one uploaded as a tape
`default_nettype none

package tb_tape_model;

	logic [7:0]  image [$];
	bit          image_p;    // .p image, written past the system variables
	int unsigned mismatches;
	int unsigned failures;
	int unsigned checks;

	function automatic void forget_image(input bit p_file);
		image.delete();
		image_p = p_file;
	endfunction

	function automatic void record_byte(input logic [7:0] b);
		image.push_back(b);
	endfunction

	function automatic int unsigned image_length();
		return image.size();
	endfunction

	function automatic logic [15:0] trap_address(input bit zx81);
		return zx81 ? 16'h0347 : 16'h0207; // ROM LOAD entry
	endfunction

	function automatic logic [15:0] expected_ram_addr(input int unsigned k);
		return 16'h4000 + (image_p ? 16'd9 : 16'd0) + 16'(k);
	endfunction

	function automatic logic [7:0] expected_ram_byte(input int unsigned k);
		return image[k];
	endfunction

	// Wait loop, byte 1 releases it and byte 5 is the ROM re-entry point
	function automatic logic [7:0] expected_patch_byte(input int idx, input bit zx81,
		input bit drained);
		logic [7:0] loop_bytes [7];
		loop_bytes = '{8'hAF, drained ? 8'h37 : 8'h00, 8'h30, 8'hFD, 8'hC3,
			zx81 ? 8'h07 : 8'h03, 8'h02};
		return loop_bytes[idx];
	endfunction

	task automatic check_value(input string what, input logic [31:0] got,
		input logic [31:0] expected);
		checks++;
		if (got !== expected) begin
			mismatches++;
			$display("mismatch at %0t: %s is %0h, expected %0h", $time, what, got, expected);
		end
	endtask

	task automatic report_failure(input string what);
		failures++;
		$display("error at %0t: %s", $time, what);
	endtask

	function automatic int unsigned error_total();
		return mismatches + failures;
	endfunction

	function automatic void print_summary();
		$display("%0d checks, %0d mismatches, %0d other errors", checks, mismatches, failures);
	endfunction

endpackage : tb_tape_model

`default_nettype wire

//--- tb/tb_zx_tape_top.sv
// Random .o and .p images through the ZX81 and ZX80 traps, checked against tb_tape_model
// Assumes the default 14-bit store and images of at most 300 bytes
`timescale 1ns/1ns
`default_nettype none

module tb_zx_tape_top
	import tb_tape_model::*;
();

	localparam int          CLK_PERIOD = 100;
	localparam logic [31:0] SEED       = 32'h2bb8_8129;

	logic        clk_sys;
	logic        reset;
	logic        ioctl_download;
	logic [7:0]  ioctl_index;
	logic        ioctl_wr;
	logic [24:0] ioctl_addr;
	logic [7:0]  ioctl_dout;
	logic [15:0] cpu_addr;
	logic        cpu_m1;
	logic        cpu_ce;
	logic        model_zx81;
	logic        tape_ready;
	logic        patch_valid;
	logic [7:0]  patch_data;
	logic        ram_we;
	logic [15:0] ram_addr;
	logic [7:0]  ram_data;

	int unsigned len_o;
	int unsigned len_p;
	int unsigned watchdog_cycles;
	int unsigned writes_seen;
	bit          writes_expected; // Cleared outside a load

	zx_tape_top #(.TAPE_AW(14)) dut0 (.*);

	initial begin
		clk_sys = 1'b0;
		forever #(CLK_PERIOD / 2) clk_sys = ~clk_sys;
	end

	// ==============================
	// Host and CPU stimulus
	// ==============================

	task automatic upload_image(input logic [7:0] index, input int unsigned len, input bit keep);
		logic [7:0] b;
		if (keep) begin
			forget_image(index[6]);
		end
		@(negedge clk_sys);
		ioctl_index    = index;
		ioctl_download = 1'b1;
		for (int unsigned k = 0; k < len; k++) begin
			b = 8'($urandom);
			if (keep) begin
				record_byte(b);
			end
			ioctl_addr = 25'(k);
			ioctl_dout = b;
			ioctl_wr   = 1'b1;
			@(negedge clk_sys);
		end
		ioctl_wr   = 1'b0;
		ioctl_addr = 25'(len); // Byte count left behind by the host
		@(negedge clk_sys);
		ioctl_download = 1'b0;
	endtask

	task automatic expect_ready(input bit level);
		repeat (8) @(negedge clk_sys);
		check_value("tape_ready", tape_ready, level);
	endtask

	task automatic fetch(input logic [15:0] addr);
		@(negedge clk_sys);
		cpu_addr = addr;
		cpu_m1   = 1'b1;
		@(negedge clk_sys);
		cpu_m1 = 1'b0;
	endtask

	// Called on a falling edge, drained is judged once the write monitor has run
	task automatic read_patch(input bit zx81, input int idx);
		cpu_addr = trap_address(zx81) + 16'(idx);
		#(CLK_PERIOD / 4);
		check_value("patch_valid", patch_valid, 1'b1);
		check_value($sformatf("patch byte %0d", idx), patch_data,
			expected_patch_byte(idx, zx81, writes_seen == image_length()));
	endtask

	task automatic expect_no_patch(input bit zx81);
		@(negedge clk_sys);
		cpu_addr = trap_address(zx81);
		#(CLK_PERIOD / 4);
		check_value("patch_valid outside a load", patch_valid, 1'b0);
	endtask

	task automatic pulse_ce(input int n);
		repeat (n) begin
			@(negedge clk_sys);
			cpu_ce = 1'b1;
			@(negedge clk_sys);
			cpu_ce = 1'b0;
		end
	endtask

	task automatic run_load(input bit zx81);
		int unsigned pulses;
		pulses          = 0;
		model_zx81      = zx81;
		writes_seen     = 0;
		writes_expected = 1'b1;
		fetch(trap_address(zx81));
		for (int i = 0; i < 7; i++) begin
			@(negedge clk_sys);
			read_patch(zx81, i); // Whole window before the first byte
		end
		@(negedge clk_sys);
		while (writes_seen < image_length() && pulses < image_length() + 8) begin
			cpu_ce = 1'b1;
			@(negedge clk_sys);
			cpu_ce = 1'b0;
			read_patch(zx81, pulses % 7);
			@(negedge clk_sys);
			pulses++;
		end
		check_value("RAM write count", writes_seen, image_length());
		for (int i = 0; i < 7; i++) begin
			@(negedge clk_sys);
			read_patch(zx81, i);
		end
		writes_expected = 1'b0;
		fetch(16'h0038); // RST 38, below both routines
		expect_no_patch(zx81);
		pulse_ce(4);
	endtask

	// ==============================
	// RAM write monitor
	// ==============================

	always @(negedge clk_sys) begin
		if (!reset && ram_we) begin
			if (!writes_expected || writes_seen >= image_length()) begin
				report_failure($sformatf("RAM write to %h while no tape byte was due", ram_addr));
			end else begin
				check_value("RAM address", ram_addr, expected_ram_addr(writes_seen));
				check_value("RAM data", ram_data, expected_ram_byte(writes_seen));
				writes_seen++;
			end
		end
	end

	initial begin
		wait (watchdog_cycles != 0);
		repeat (watchdog_cycles) @(posedge clk_sys);
		$display("Watchdog expired after %0d cycles, the test did not finish", watchdog_cycles);
		print_summary();
		$display("Simulation FAILED");
		$finish;
	end

	// ==============================
	// Test sequence
	// ==============================

	initial begin
		reset           = 1'b1;
		ioctl_download  = 1'b0;
		ioctl_index     = 8'h00;
		ioctl_wr        = 1'b0;
		ioctl_addr      = '0;
		ioctl_dout      = 8'h00;
		cpu_addr        = 16'h0000;
		cpu_m1          = 1'b0;
		cpu_ce          = 1'b0;
		model_zx81      = 1'b1;
		writes_seen     = 0;
		writes_expected = 1'b0;
		void'($urandom(SEED));
		len_o           = 1 + $urandom % 300;
		len_p           = 1 + $urandom % 300;
		watchdog_cycles = (len_o + len_p + 16) * 4 + 2000;

		repeat (16) @(negedge clk_sys);
		reset = 1'b0;
		check_value("tape_ready after reset", tape_ready, 1'b0);
		check_value("ram_we after reset", ram_we, 1'b0);
		check_value("patch_valid after reset", patch_valid, 1'b0);

		// No tape, so the trap must be ignored
		fetch(trap_address(1'b1));
		pulse_ce(4);
		expect_no_patch(1'b1);

		upload_image(8'h21, 16, 1'b0); // Aux upload, not a tape
		expect_ready(1'b0);

		upload_image(8'h01, len_o, 1'b1);
		expect_ready(1'b1);
		run_load(1'b1);

		upload_image(8'h41, len_p, 1'b1); // .p image on the ZX80
		expect_ready(1'b1);
		run_load(1'b0);

		print_summary();
		if (error_total() == 0) begin
			$display("Simulation PASSED");
		end else begin
			$display("Simulation FAILED");
		end
		$finish;
	end

endmodule : tb_zx_tape_top

`default_nettype wire
